// File: hdl/eeprom_cfg.svh
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// CLK cycles per quarter of an SCL period
`define SCL_QUARTER 2

// 24C16 style device code, upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

// 2 KiB array
`define EE_ADDR_W 11

`endif

// File: hdl/eeprom_pkg.sv
`include "eeprom_cfg.svh"

package eeprom_pkg;

    typedef logic [7:0] ee_byte_t;
    typedef logic [`EE_ADDR_W-1:0] ee_addr_t;

    // value doubles as the R/W bit of the control byte
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } ee_op_e;

    typedef struct packed {
        ee_op_e   op;
        ee_addr_t addr;
        ee_byte_t wdata;
    } eeprom_req_t;

    typedef struct packed {
        ee_byte_t rdata;
        logic     nack;
    } eeprom_resp_t;

    typedef enum logic [1:0] {
        BK_START,
        BK_STOP,
        BK_SEND,
        BK_RECV
    } bit_kind_e;

    typedef struct packed {
        bit_kind_e kind;
        ee_byte_t  tx;
        logic      ack_bit; // sda level in the ack slot of a receive, 1 = nack
    } byte_cmd_t;

    typedef enum logic [3:0] {
        CS_IDLE,
        CS_START,
        CS_CTRL_WR,
        CS_ADDR,
        CS_DATA_WR,
        CS_RD_START,
        CS_CTRL_RD,
        CS_DATA_RD,
        CS_STOP,
        CS_ACKN
    } ctrl_state_e;

    typedef enum logic [2:0] {
        ES_IDLE,
        ES_HEAD,
        ES_STOP,
        ES_SHOUT,
        ES_SHIN
    } engine_state_e;

endpackage

// File: hdl/i2c_byte_engine.sv
`include "eeprom_cfg.svh"

module i2c_byte_engine import eeprom_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      cmd_valid,
    input  byte_cmd_t cmd,
    output logic      cmd_done,
    output ee_byte_t  rx_byte,
    output logic      rx_nack,
    output logic      scl,
    output logic      sda_drive_low,
    input  logic      sda_in
);

    localparam int QW = $clog2(`SCL_QUARTER + 1);
    localparam logic [QW-1:0] Q_LAST = QW'(`SCL_QUARTER - 1);
    localparam logic [3:0] ACK_SLOT = 4'd8;

    // each bit: phase 0,1 scl low, phase 2,3 scl high
    engine_state_e   state;
    logic [QW-1:0]   qcnt;
    logic [1:0]      phase;
    logic [3:0]      bitcnt;
    logic            running;   // scl has left idle since the last start
    ee_byte_t        shreg;
    logic            ack_lvl;

    logic accept;
    logic quarter_end;
    logic shifting;
    logic last_bit;
    logic sample_data;

    assign accept      = (state == ES_IDLE) && cmd_valid;
    assign quarter_end = (state != ES_IDLE) && (qcnt == Q_LAST);
    assign shifting    = (state == ES_SHOUT) || (state == ES_SHIN);
    assign last_bit    = !shifting || (bitcnt == ACK_SLOT);

    // middle of scl high on a data bit
    assign sample_data = quarter_end && (phase == 2'd1 + 2'd1) && shifting
                         && (bitcnt != ACK_SLOT);

    assign rx_byte = shreg;

    // quarter counter, wraps back to zero at the end of every command
    always_ff @(posedge CLK) begin
        if (RESET) begin
            qcnt  <= '0;
            phase <= 2'd0;
        end else if (state != ES_IDLE) begin
            if (quarter_end) begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
            end else begin
                qcnt <= qcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state         <= ES_IDLE;
            bitcnt        <= '0;
            running       <= 1'b0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            cmd_done      <= 1'b0;
            rx_nack       <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            if (accept) begin
                bitcnt <= '0;
                unique case (cmd.kind)
                    BK_START: begin
                        state <= ES_HEAD;
                        scl   <= !running; // repeated start drops scl first
                    end
                    BK_STOP: begin
                        state <= ES_STOP;
                        scl   <= 1'b0;
                    end
                    BK_SEND: begin
                        state <= ES_SHOUT;
                        scl   <= 1'b0;
                    end
                    BK_RECV: begin
                        state <= ES_SHIN;
                        scl   <= 1'b0;
                    end
                endcase
            end else if (quarter_end) begin
                unique case (phase)
                    2'd0: begin
                        // middle of scl low, the only place data may move
                        case (state)
                            ES_HEAD:  sda_drive_low <= 1'b0;
                            ES_STOP:  sda_drive_low <= 1'b1;
                            ES_SHOUT: begin
                                if (bitcnt == ACK_SLOT) begin
                                    sda_drive_low <= 1'b0; // let the slave ack
                                end else begin
                                    sda_drive_low <= !shreg[7];
                                end
                            end
                            ES_SHIN: begin
                                if (bitcnt == ACK_SLOT) begin
                                    sda_drive_low <= !ack_lvl;
                                end else begin
                                    sda_drive_low <= 1'b0;
                                end
                            end
                            default: ;
                        endcase
                    end
                    2'd1: scl <= 1'b1;
                    2'd2: begin
                        // middle of scl high
                        case (state)
                            ES_HEAD:  sda_drive_low <= 1'b1; // start condition
                            ES_STOP:  sda_drive_low <= 1'b0; // stop condition
                            ES_SHOUT: begin
                                if (bitcnt == ACK_SLOT) begin
                                    rx_nack <= sda_in;
                                end
                            end
                            default: ;
                        endcase
                    end
                    2'd3: begin
                        if (last_bit) begin
                            state    <= ES_IDLE;
                            cmd_done <= 1'b1;
                            if (state == ES_HEAD) begin
                                running <= 1'b1;
                            end
                            if (state == ES_STOP) begin
                                running <= 1'b0;
                            end
                        end else begin
                            bitcnt <= bitcnt + 4'd1;
                            scl    <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

    // one register for both directions, msb first
    always_ff @(posedge CLK) begin
        if (accept) begin
            shreg   <= cmd.tx;
            ack_lvl <= cmd.ack_bit;
        end else if (sample_data) begin
            shreg <= {shreg[6:0], sda_in};
        end
    end

endmodule

// File: hdl/eeprom_ctrl.sv
`include "eeprom_cfg.svh"

module eeprom_ctrl import eeprom_pkg::*; (
    input  logic         CLK,
    input  logic         RESET,
    input  logic         req_valid,
    input  eeprom_req_t  req,
    output logic         ack,
    output eeprom_resp_t resp,
    output logic         cmd_valid,
    output byte_cmd_t    cmd,
    input  logic         cmd_done,
    input  ee_byte_t     rx_byte,
    input  logic         rx_nack
);

    ctrl_state_e state;
    ctrl_state_e next_state;
    eeprom_req_t req_q;
    ee_byte_t    rdata_q;
    logic        nack_q;
    logic        sent_byte;

    function automatic ee_byte_t ctrl_byte(input ee_addr_t addr, input logic rw);
        return {`EE_DEV_CODE, addr[`EE_ADDR_W-1 -: 3], rw};
    endfunction

    assign sent_byte = (state == CS_CTRL_WR) || (state == CS_ADDR) ||
                       (state == CS_DATA_WR) || (state == CS_CTRL_RD);

    always_comb begin
        case (state)
            CS_START:    next_state = CS_CTRL_WR;
            CS_CTRL_WR:  next_state = rx_nack ? CS_STOP : CS_ADDR;
            CS_ADDR: begin
                if (rx_nack) begin
                    next_state = CS_STOP;
                end else if (req_q.op == OP_WRITE) begin
                    next_state = CS_DATA_WR;
                end else begin
                    next_state = CS_RD_START;
                end
            end
            CS_DATA_WR:  next_state = CS_STOP;
            CS_RD_START: next_state = CS_CTRL_RD;
            CS_CTRL_RD:  next_state = rx_nack ? CS_STOP : CS_DATA_RD;
            CS_DATA_RD:  next_state = CS_STOP;
            CS_STOP:     next_state = CS_ACKN;
            default:     next_state = CS_IDLE;
        endcase
    end

    // command belongs to the state just entered
    always_comb begin
        cmd.kind    = BK_STOP;
        cmd.tx      = '0;
        cmd.ack_bit = 1'b0;
        case (state)
            CS_START, CS_RD_START: cmd.kind = BK_START;
            CS_CTRL_WR: begin
                cmd.kind = BK_SEND;
                cmd.tx   = ctrl_byte(req_q.addr, OP_WRITE);
            end
            CS_ADDR: begin
                cmd.kind = BK_SEND;
                cmd.tx   = req_q.addr[7:0];
            end
            CS_DATA_WR: begin
                cmd.kind = BK_SEND;
                cmd.tx   = req_q.wdata;
            end
            CS_CTRL_RD: begin
                cmd.kind = BK_SEND;
                cmd.tx   = ctrl_byte(req_q.addr, OP_READ);
            end
            CS_DATA_RD: begin
                cmd.kind    = BK_RECV;
                cmd.ack_bit = 1'b1; // single byte read ends with nack
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= CS_IDLE;
            cmd_valid <= 1'b0;
            nack_q    <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            case (state)
                CS_IDLE: begin
                    if (req_valid) begin
                        state     <= CS_START;
                        cmd_valid <= 1'b1;
                        nack_q    <= 1'b0;
                    end
                end
                CS_ACKN: state <= CS_IDLE;
                default: begin
                    if (cmd_done) begin
                        state     <= next_state;
                        cmd_valid <= (state != CS_STOP); // every other step issues a command
                        if (sent_byte) begin
                            nack_q <= rx_nack;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == CS_IDLE && req_valid) begin
            req_q <= req;
        end
        if (state == CS_DATA_RD && cmd_done) begin
            rdata_q <= rx_byte;
        end
    end

    assign ack        = (state == CS_ACKN);
    assign resp.rdata = rdata_q;
    assign resp.nack  = nack_q;

endmodule

// File: hdl/eeprom_if_top.sv
module eeprom_if_top import eeprom_pkg::*; (
    input  logic         CLK,
    input  logic         RESET,
    input  logic         req_valid,
    input  eeprom_req_t  req,
    output logic         ack,
    output eeprom_resp_t resp,
    output logic         scl,
    inout  wire          sda
);

    logic      cmd_valid;
    byte_cmd_t cmd;
    logic      cmd_done;
    ee_byte_t  rx_byte;
    logic      rx_nack;
    logic      sda_drive_low;
    logic      sda_in;

    eeprom_ctrl u_ctrl (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .ack       (ack),
        .resp      (resp),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .rx_nack   (rx_nack)
    );

    i2c_byte_engine u_engine (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .cmd_done      (cmd_done),
        .rx_byte       (rx_byte),
        .rx_nack       (rx_nack),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

    // open drain, pull-up sits outside
    assign sda    = sda_drive_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

endmodule

// File: sim/eeprom_model.sv
`include "eeprom_cfg.svh"

module eeprom_model import eeprom_pkg::*; #(
    parameter int busy_cycles = 400
) (
    input  logic CLK,
    input  logic scl,
    inout  wire  sda,
    output int   start_cnt,
    output int   stop_cnt,
    output int   frame_err_cnt
);

    typedef enum logic [2:0] {
        MS_IDLE,
        MS_CTRL,
        MS_ADDR,
        MS_WDATA,
        MS_RDATA,
        MS_DONE
    } model_state_e;

    ee_byte_t     mem [0:(1 << `EE_ADDR_W) - 1];
    model_state_e mstate = MS_IDLE;
    model_state_e after_ack = MS_DONE;
    int           bit_idx = 0;   // scl rises seen in the current byte
    int           busy_left = 0;
    ee_byte_t     shreg = '0;
    ee_byte_t     tx = '0;
    ee_byte_t     wbyte = '0;
    ee_addr_t     addr = '0;
    logic         have_wdata = 1'b0;
    logic         sda_low = 1'b0;

    assign sda = sda_low ? 1'b0 : 1'bz;

    initial begin
        start_cnt     = 0;
        stop_cnt      = 0;
        frame_err_cnt = 0;
    end

    // start: sda falls with scl high
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            if (bit_idx > 1) frame_err_cnt++; // inside a byte
            start_cnt++;
            mstate     = MS_CTRL;
            bit_idx    = 0;
            have_wdata = 1'b0;
        end
    end

    // stop: sda rises with scl high
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            if (bit_idx > 1) frame_err_cnt++;
            stop_cnt++;
            if (have_wdata) begin
                mem[addr] = wbyte;
                busy_left = busy_cycles; // internal write cycle starts
            end
            have_wdata = 1'b0;
            mstate     = MS_IDLE;
            bit_idx    = 0;
        end
    end

    always @(posedge scl) begin
        if (mstate != MS_IDLE) begin
            if (bit_idx < 8 && mstate != MS_RDATA) begin
                shreg = {shreg[6:0], sda};
            end
            bit_idx = bit_idx + 1;
        end
    end

    // sda only moves while scl is low
    always @(negedge scl) begin
        if (mstate != MS_IDLE) begin
            if (bit_idx == 9) begin
                bit_idx = 0;
                sda_low = 1'b0;
                mstate  = after_ack;
                if (mstate == MS_RDATA) tx = mem[addr];
            end
            if (bit_idx == 8) begin
                sda_low = 1'b0;
                case (mstate)
                    MS_CTRL: begin
                        if (shreg[7:4] == `EE_DEV_CODE && busy_left == 0) begin
                            sda_low = 1'b1;
                            addr[`EE_ADDR_W-1 -: 3] = shreg[3:1];
                            after_ack = shreg[0] ? MS_RDATA : MS_ADDR;
                        end else begin
                            after_ack = MS_DONE; // busy or other device
                        end
                    end
                    MS_ADDR: begin
                        sda_low   = 1'b1;
                        addr[7:0] = shreg;
                        after_ack = MS_WDATA;
                    end
                    MS_WDATA: begin
                        sda_low    = 1'b1;
                        wbyte      = shreg;
                        have_wdata = 1'b1;
                        after_ack  = MS_DONE;
                    end
                    default: after_ack = MS_DONE;
                endcase
            end else if (bit_idx < 8 && mstate == MS_RDATA) begin
                sda_low = !tx[7 - bit_idx];
            end
        end
    end

    always @(posedge CLK) begin
        if (busy_left > 0) busy_left = busy_left - 1;
    end

endmodule

// File: sim/tb_eeprom.sv
`include "eeprom_cfg.svh"

module tb_eeprom import eeprom_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int EE_BUSY    = 400;
    localparam int N_XFER     = 67;
    localparam int BIT_CLKS   = 4 * `SCL_QUARTER;
    localparam int MAX_CYCLES = N_XFER * (45 * BIT_CLKS + EE_BUSY) + 1000;

    logic         CLK;
    logic         RESET;
    logic         req_valid;
    eeprom_req_t  req;
    logic         ack;
    eeprom_resp_t resp;
    logic         scl;
    wire          sda;
    int           start_cnt;
    int           stop_cnt;
    int           frame_err_cnt;
    ee_byte_t     ref_mem [0:(1 << `EE_ADDR_W) - 1];
    logic [31:0]  rng;
    int           cycles;
    int           value_errs;
    int           hs_errs;
    int           bus_errs;
    // what the request in flight should return
    logic         exp_nack;
    logic         exp_read;
    ee_byte_t     exp_rdata;
    int           exp_starts;
    int           start_base;
    int           stop_base;
    int           req_id;
    int           acked_id;

    pullup (sda);

    eeprom_if_top uut (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .ack       (ack),
        .resp      (resp),
        .scl       (scl),
        .sda       (sda)
    );

    eeprom_model #(.busy_cycles(EE_BUSY)) slave (
        .CLK           (CLK),
        .scl           (scl),
        .sda           (sda),
        .start_cnt     (start_cnt),
        .stop_cnt      (stop_cnt),
        .frame_err_cnt (frame_err_cnt)
    );

    always #5 CLK = ~CLK;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic flag_error(input int kind, input string msg);
        case (kind)
            0: value_errs++;
            1: hs_errs++;
            default: bus_errs++;
        endcase
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic transfer(input ee_op_e op, input ee_addr_t addr, input ee_byte_t wdata,
                            input logic nack_exp);
        @(posedge CLK);
        req_valid  <= 1'b1;
        req        <= '{op: op, addr: addr, wdata: wdata};
        exp_nack   <= nack_exp;
        exp_read   <= (op == OP_READ);
        exp_rdata  <= ref_mem[addr];
        exp_starts <= (op == OP_READ) ? 2 : 1;
        start_base <= start_cnt;
        stop_base  <= stop_cnt;
        req_id     <= req_id + 1;
        @(negedge CLK);
        while (ack !== 1'b1) @(negedge CLK);
        if (op == OP_WRITE && nack_exp == 1'b0) ref_mem[addr] = wdata;
        @(posedge CLK);
        req_valid <= 1'b0;
    endtask

    task automatic wait_busy();
        repeat (EE_BUSY + 20) @(posedge CLK);
    endtask

    assert property (@(posedge CLK) disable iff (RESET) ack |-> resp.nack == exp_nack)
        else flag_error(0, "nack flag differs from the expected one");
    assert property (@(posedge CLK) disable iff (RESET)
        ack && exp_read && !exp_nack |-> resp.rdata == exp_rdata)
        else flag_error(0, "read data differs from the reference memory");
    assert property (@(posedge CLK) disable iff (RESET) ack |-> req_valid)
        else flag_error(1, "ack without a pending request");
    assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
        else flag_error(1, "ack longer than one cycle");
    assert property (@(posedge CLK) disable iff (RESET) ack |-> acked_id != req_id)
        else flag_error(1, "second ack for one request");
    assert property (@(posedge CLK) RESET |=> !ack && scl === 1'b1 && sda === 1'b1)
        else flag_error(1, "bus not released or ack high after reset");
    assert property (@(posedge CLK) $stable(frame_err_cnt))
        else flag_error(2, "sda moved with scl high inside a byte");
    assert property (@(posedge CLK) disable iff (RESET) ack |-> stop_cnt - stop_base == 1)
        else flag_error(2, "transfer did not end with exactly one stop");
    assert property (@(posedge CLK) disable iff (RESET)
        ack && !exp_nack |-> start_cnt - start_base == exp_starts)
        else flag_error(2, "wrong number of start conditions");

    always @(posedge CLK) begin
        if (ack) acked_id <= req_id;
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run still busy after %0d clock cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        ee_addr_t a;
        ee_addr_t addrs [20];
        CLK        = 1'b0;
        RESET      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        rng        = 32'ha7e0;
        cycles     = 0;
        value_errs = 0;
        hs_errs    = 0;
        bus_errs   = 0;
        exp_nack   = 1'b0;
        exp_read   = 1'b0;
        exp_rdata  = '0;
        exp_starts = 0;
        start_base = 0;
        stop_base  = 0;
        req_id     = 0;
        acked_id   = -1;
        for (int i = 0; i < (1 << `EE_ADDR_W); i++) begin
            ref_mem[i]   = ee_byte_t'(i * 29) ^ ee_byte_t'(i >> 3);
            slave.mem[i] = ref_mem[i];
        end
        repeat (2) @(posedge CLK);
        RESET <= 1'b0;
        repeat (4) @(posedge CLK);

        rng = xorshift(rng);
        a   = rng[10:0];
        transfer(OP_WRITE, a, rng[23:16], 1'b0);
        wait_busy();
        transfer(OP_READ, a, 8'h00, 1'b0);

        // every value of the page bits gets at least two writes
        for (int i = 0; i < 20; i++) begin
            rng      = xorshift(rng);
            addrs[i] = {3'(i % 8), rng[7:0]};
            transfer(OP_WRITE, addrs[i], rng[15:8], 1'b0);
            wait_busy();
        end
        for (int i = 0; i < 20; i++) begin
            transfer(OP_READ, addrs[i], 8'h00, 1'b0);
            // same low byte in another page, catches lost page bits
            transfer(OP_READ, addrs[i] ^ 11'h400, 8'h00, 1'b0);
        end

        rng = xorshift(rng);
        a   = rng[10:0];
        transfer(OP_WRITE, a, rng[23:16], 1'b0);
        transfer(OP_READ, a, 8'h00, 1'b1);   // still in the write cycle
        wait_busy();
        rng = xorshift(rng);
        a   = rng[10:0];
        transfer(OP_WRITE, a, rng[23:16], 1'b0);
        transfer(OP_WRITE, a, ~rng[23:16], 1'b1);
        wait_busy();
        transfer(OP_READ, a, 8'h00, 1'b0);

        repeat (10) @(posedge CLK);
        $display("errors: value %0d, handshake %0d, bus %0d", value_errs, hs_errs, bus_errs);
        if (value_errs + hs_errs + bus_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+hdl
hdl/eeprom_pkg.sv
hdl/i2c_byte_engine.sv
hdl/eeprom_ctrl.sv
hdl/eeprom_if_top.sv
sim/eeprom_model.sv
sim/tb_eeprom.sv

// File: Bender.yml
package:
  name: eeprom_if

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/eeprom_pkg.sv
      - hdl/i2c_byte_engine.sv
      - hdl/eeprom_ctrl.sv
      - hdl/eeprom_if_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/eeprom_model.sv
      - sim/tb_eeprom.sv
